//--- hw/ifu_pkg.sv
package ifu_pkg;

  localparam int XLEN = 32;

  // fetch starts here after reset.
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // opcodes that change the flow of control.
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // icache geometry, four sets of two-word lines.
  localparam int IC_SETS_LOG = 2;
  localparam int IC_LINE_LOG = 1;
  localparam int IC_SETS     = 2 ** IC_SETS_LOG;
  localparam int IC_WORDS    = 2 ** IC_LINE_LOG;
  localparam int IC_OFF_LSB  = 2;                          // byte offset within a word.
  localparam int IC_IDX_LSB  = IC_OFF_LSB + IC_LINE_LOG;
  localparam int IC_TAG_LSB  = IC_IDX_LSB + IC_SETS_LOG;
  localparam int IC_TAG_W    = XLEN - IC_TAG_LSB;

  // btb is indexed by pc[3:2].
  localparam int BTB_LOG     = 2;
  localparam int BTB_ENTRIES = 2 ** BTB_LOG;

  // why fetch is held.
  typedef enum logic [1:0] {
    STALL_NONE   = 2'd0,
    STALL_BRANCH = 2'd1, // control instruction waits for its resolution.
    STALL_FENCE  = 2'd2  // fence.i waits to flush the cache.
  } ifu_stall_e;

endpackage

//--- hw/icache_if.sv
`timescale 1ns/10ps

interface icache_if import ifu_pkg::*; ();

  logic [XLEN-1:0] fetch_pc;
  logic            flush;    // one-cycle pulse, taken only while idle.
  logic            hit;      // inst holds the word at fetch_pc.
  logic [XLEN-1:0] inst;
  logic            idle;     // no refill in progress.

  modport ctrl (
    output fetch_pc, flush,
    input  hit, inst, idle
  );

  modport cache (
    input  fetch_pc, flush,
    output hit, inst, idle
  );

endinterface

//--- hw/btb.sv
`timescale 1ns/10ps

module btb import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] lookup_pc_i,
  output logic            hit_o,
  output logic [XLEN-1:0] target_o,
  input  logic            upd_valid_i,
  input  logic [XLEN-1:0] upd_pc_i,
  input  logic [XLEN-1:0] upd_npc_i
);

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [XLEN-1:0]        tag_q    [BTB_ENTRIES];
  logic [XLEN-1:0]        target_q [BTB_ENTRIES];

  logic [BTB_LOG-1:0] rd_idx;
  logic [BTB_LOG-1:0] wr_idx;

  assign rd_idx = lookup_pc_i[BTB_LOG+1:2];
  assign wr_idx = upd_pc_i[BTB_LOG+1:2];

  // the whole pc is kept as tag, so aliasing never gives a false hit.
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc_i);
  assign target_o = target_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (upd_valid_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // every resolution overwrites its entry with the actual next pc.
  always_ff @(posedge clk) begin
    if (upd_valid_i) begin
      tag_q[wr_idx]    <= upd_pc_i;
      target_q[wr_idx] <= upd_npc_i;
    end
  end

endmodule

//--- hw/icache.sv
`timescale 1ns/10ps

module icache import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  icache_if.cache         ic,
  output logic [XLEN-1:0] araddr_o,
  output logic            arvalid_o,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            rvalid_i
);

  typedef enum logic [1:0] {
    RF_IDLE   = 2'd0,
    RF_EVEN   = 2'd1,
    RF_ODD    = 2'd2,
    RF_SETTLE = 2'd3
  } refill_e;

  refill_e state_q;

  logic [IC_SETS-1:0]  valid_q;                 // a set turns valid once both words are in.
  logic [XLEN-1:0]     data_q [IC_SETS][IC_WORDS];
  logic [IC_TAG_W-1:0] tag_q  [IC_SETS][IC_WORDS];

  logic [XLEN-1:0] araddr_q;
  logic            arvalid_q;

  // lookup fields of the fetch pc.
  logic [IC_TAG_W-1:0]    pc_tag;
  logic [IC_SETS_LOG-1:0] pc_idx;
  logic [IC_LINE_LOG-1:0] pc_off;

  // fields of the word on the bus.
  logic [IC_TAG_W-1:0]    rf_tag;
  logic [IC_SETS_LOG-1:0] rf_idx;
  logic [IC_LINE_LOG-1:0] rf_off;
  logic                   fill;

  assign pc_tag = ic.fetch_pc[XLEN-1:IC_TAG_LSB];
  assign pc_idx = ic.fetch_pc[IC_TAG_LSB-1:IC_IDX_LSB];
  assign pc_off = ic.fetch_pc[IC_IDX_LSB-1:IC_OFF_LSB];

  assign rf_tag = araddr_q[XLEN-1:IC_TAG_LSB];
  assign rf_idx = araddr_q[IC_TAG_LSB-1:IC_IDX_LSB];
  assign rf_off = araddr_q[IC_IDX_LSB-1:IC_OFF_LSB];

  assign fill = arvalid_q && rvalid_i;

  // lookups are only answered between refills.
  assign ic.hit  = (state_q == RF_IDLE) && valid_q[pc_idx] && (tag_q[pc_idx][pc_off] == pc_tag);
  assign ic.inst = data_q[pc_idx][pc_off];
  assign ic.idle = (state_q == RF_IDLE);

  assign araddr_o  = araddr_q;
  assign arvalid_o = arvalid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= RF_IDLE;
      valid_q   <= '0;
      arvalid_q <= 1'b0;
    end else begin
      case (state_q)
        RF_IDLE: begin
          if (ic.flush) begin
            valid_q <= '0;
          end else if (!ic.hit) begin
            state_q   <= RF_EVEN;
            arvalid_q <= 1'b1;
          end
        end
        RF_EVEN: begin
          if (fill) begin
            state_q   <= RF_ODD;
            arvalid_q <= 1'b0; // request drops for a cycle between the two reads.
          end
        end
        RF_ODD: begin
          if (!arvalid_q) begin
            arvalid_q <= 1'b1;
          end else if (fill) begin
            arvalid_q       <= 1'b0;
            valid_q[rf_idx] <= 1'b1;
            state_q         <= RF_SETTLE;
          end
        end
        RF_SETTLE: begin
          state_q <= RF_IDLE;
        end
        default: begin
          state_q <= RF_IDLE;
        end
      endcase
    end
  end

  // the refill address is latched, since the pc may be redirected mid refill.
  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE && !ic.flush && !ic.hit) begin
      araddr_q <= {ic.fetch_pc[XLEN-1:IC_IDX_LSB], {IC_IDX_LSB{1'b0}}};
    end else if (state_q == RF_ODD && !arvalid_q) begin
      araddr_q[IC_IDX_LSB-1:IC_OFF_LSB] <= IC_LINE_LOG'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      data_q[rf_idx][rf_off] <= rdata_i;
      tag_q[rf_idx][rf_off]  <= rf_tag;
    end
  end

endmodule

//--- hw/ifu_ctrl.sv
`timescale 1ns/10ps

module ifu_ctrl import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  icache_if.ctrl          ic,
  input  logic            btb_hit_i,
  input  logic [XLEN-1:0] btb_target_i,
  input  logic            resolve_valid_i,
  input  logic [XLEN-1:0] resolve_pc_i,
  input  logic [XLEN-1:0] resolve_npc_i,
  input  logic            next_ready_i,
  output logic            valid_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] inst_o,
  output logic            spec_o,
  output logic            mispredict_o
);

  logic [XLEN-1:0] pc_q;
  ifu_stall_e      stall_q;
  logic            spec_q;
  logic [XLEN-1:0] spec_pc_q;     // pc of the predicted control instruction.
  logic [XLEN-1:0] spec_target_q; // next pc that the btb gave for it.

  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_fence;
  logic       spec_hold;
  logic       fire;
  logic       res_stall;
  logic       res_spec;

  // predecode.
  assign opcode   = ic.inst[6:0];
  assign is_ctrl  = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                    (opcode == OP_BRANCH) || (opcode == OP_SYSTEM);
  assign is_fence = (ic.inst == INST_FENCE_I);

  // at most one control instruction is unresolved, so the pc alone identifies it.
  assign res_stall = resolve_valid_i && (stall_q == STALL_BRANCH) && (resolve_pc_i == pc_q);
  assign res_spec  = resolve_valid_i && spec_q && (resolve_pc_i == spec_pc_q);

  assign mispredict_o = res_spec && (resolve_npc_i != spec_target_q);

  // while speculating, another control instruction or a fence.i waits.
  assign spec_hold = spec_q && (is_ctrl || is_fence);

  assign valid_o = ic.hit && (stall_q == STALL_NONE) && !spec_hold && !mispredict_o;
  assign fire    = valid_o && next_ready_i;

  assign pc_o   = pc_q;
  assign inst_o = ic.inst;
  assign spec_o = spec_q;

  assign ic.fetch_pc = pc_q;
  assign ic.flush    = (stall_q == STALL_FENCE) && ic.idle;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= PC_INIT;
      stall_q <= STALL_NONE;
      spec_q  <= 1'b0;
    end else begin
      if (fire) begin
        if (is_fence) begin
          stall_q <= STALL_FENCE;
        end else if (is_ctrl && btb_hit_i) begin
          pc_q   <= btb_target_i; // follow the prediction.
          spec_q <= 1'b1;
        end else if (is_ctrl) begin
          stall_q <= STALL_BRANCH; // target unknown.
        end else begin
          pc_q <= pc_q + XLEN'(4);
        end
      end

      // fence.i moves on past itself once the flush went out.
      if (ic.flush) begin
        stall_q <= STALL_NONE;
        pc_q    <= pc_q + XLEN'(4);
      end

      if (res_stall) begin
        stall_q <= STALL_NONE;
        pc_q    <= resolve_npc_i;
      end

      if (res_spec) begin
        spec_q <= 1'b0;
        if (mispredict_o) begin
          pc_q <= resolve_npc_i; // the wrong path is dropped downstream.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && is_ctrl && btb_hit_i) begin
      spec_pc_q     <= pc_q;
      spec_target_q <= btb_target_i;
    end
  end

endmodule

//--- hw/ifu_top.sv
`timescale 1ns/10ps

module ifu_top import ifu_pkg::*; (
  input  logic            clk,
  input  logic            rst,

  // memory read bus.
  output logic [XLEN-1:0] araddr_o,
  output logic            arvalid_o,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            rvalid_i,

  // next stage.
  input  logic            next_ready_i,
  output logic            valid_o,
  output logic [XLEN-1:0] pc_o,
  output logic [XLEN-1:0] inst_o,

  // resolution from execute.
  input  logic            resolve_valid_i,
  input  logic [XLEN-1:0] resolve_pc_i,
  input  logic [XLEN-1:0] resolve_npc_i,

  output logic            spec_o,
  output logic            mispredict_o
);

  icache_if ic ();

  logic            btb_hit;
  logic [XLEN-1:0] btb_target;

  ifu_ctrl i_ifu_ctrl (
    .clk             (clk),
    .rst             (rst),
    .ic              (ic.ctrl),
    .btb_hit_i       (btb_hit),
    .btb_target_i    (btb_target),
    .resolve_valid_i (resolve_valid_i),
    .resolve_pc_i    (resolve_pc_i),
    .resolve_npc_i   (resolve_npc_i),
    .next_ready_i    (next_ready_i),
    .valid_o         (valid_o),
    .pc_o            (pc_o),
    .inst_o          (inst_o),
    .spec_o          (spec_o),
    .mispredict_o    (mispredict_o)
  );

  icache i_icache (
    .clk       (clk),
    .rst       (rst),
    .ic        (ic.cache),
    .araddr_o  (araddr_o),
    .arvalid_o (arvalid_o),
    .rdata_i   (rdata_i),
    .rvalid_i  (rvalid_i)
  );

  // the btb learns from every resolution straight off the ports.
  btb i_btb (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc_i (ic.fetch_pc),
    .hit_o       (btb_hit),
    .target_o    (btb_target),
    .upd_valid_i (resolve_valid_i),
    .upd_pc_i    (resolve_pc_i),
    .upd_npc_i   (resolve_npc_i)
  );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk,
  output logic rst
);

  int unsigned rst_cnt = 10; // reset is held for ten rising edges.

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (rst_req_i) begin
      rst_cnt <= 10;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign rst = (rst_cnt != 0);

endmodule

//--- verification/ifu_chk.sv
`timescale 1ns/10ps

module ifu_chk import ifu_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic [XLEN-1:0] araddr_o,
  input logic            arvalid_o,
  input logic            rvalid_i,
  input logic [XLEN-1:0] pc_o,
  input logic            spec_o,
  input logic [XLEN-1:0] resolve_npc_i,
  input logic            mispredict_o
);

  int fail_cnt = 0;

  // a pending read keeps its address until the data strobe.
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
      arvalid_o && !rvalid_i |=> $stable(araddr_o))
    else begin
      $error("araddr_o changed while a read was pending");
      fail_cnt++;
    end

  // a mispredict ends speculation and moves fetch to the resolved pc.
  a_redirect_on_mispredict: assert property (@(posedge clk) disable iff (rst)
      mispredict_o |=> !spec_o && (pc_o == $past(resolve_npc_i)))
    else begin
      $error("fetch was not redirected after a mispredict");
      fail_cnt++;
    end

  a_idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !arvalid_o)
    else begin
      $error("arvalid_o was high in the first cycle after reset");
      fail_cnt++;
    end

endmodule

//--- verification/tb_ifu.sv
`timescale 1ns/10ps

module tb_ifu import ifu_pkg::*; ();

  localparam string       TEST_FILE  = "verification/ifu_tests.txt";
  localparam logic [31:0] LFSR_SEED  = 32'd22;
  localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
  localparam int          FILE_WORDS = 512;
  localparam int          MEM_WORDS  = 64;
  localparam int          MAX_STREAM = 32;

  logic clk, rst, rst_req;
  logic [XLEN-1:0] araddr_o, rdata_i, pc_o, inst_o, resolve_pc_i, resolve_npc_i;
  logic arvalid_o, rvalid_i, next_ready_i, valid_o, resolve_valid_i, spec_o, mispredict_o;

  logic [31:0] tdata [FILE_WORDS];
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_pc [MAX_STREAM];
  logic [31:0] exp_inst [MAX_STREAM];
  logic [31:0] patch_addr [4];
  logic [31:0] patch_data [4];
  logic [31:0] spq_pc [$];   // speculative instructions waiting for their branch.
  logic [31:0] spq_inst [$];
  logic        btb_v [4];
  logic [31:0] btb_tag [4];
  logic [31:0] btb_tgt [4];

  logic [31:0] lfsr, fence_pc, res_pc, res_npc, nxt_rdata;
  logic        mem_busy, spec_chk, nxt_rvalid, nxt_ready, nxt_resolve;
  int errors, failed, test_errs, cycles, limit, mem_wait, res_wait;
  int pos, nstream, npatch, mis_cnt, bus_cnt, backpressure;

  tb_clk_gen i_tb_clk_gen (.rst_req_i(rst_req), .clk(clk), .rst(rst));

  ifu_top i_ifu_top (
    .clk(clk), .rst(rst), .araddr_o(araddr_o), .arvalid_o(arvalid_o), .rdata_i(rdata_i),
    .rvalid_i(rvalid_i), .next_ready_i(next_ready_i), .valid_o(valid_o), .pc_o(pc_o),
    .inst_o(inst_o), .resolve_valid_i(resolve_valid_i), .resolve_pc_i(resolve_pc_i),
    .resolve_npc_i(resolve_npc_i), .spec_o(spec_o), .mispredict_o(mispredict_o)
  );

  bind ifu_top ifu_chk i_ifu_chk (.*);

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: the stream did not finish within %0d cycles", limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic int take_bits(input int n);
    int val;
    val = 0;
    repeat (n) begin
      val = (val << 1) | lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
    end
    return val;
  endfunction

  // words outside the image decode as addi, never as a control instruction.
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[31:7] ^ addr[24:0], 7'h13};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - PC_INIT) >> 2;
    if (addr >= PC_INIT && idx < MEM_WORDS) return mem[idx];
    return fill_word(addr);
  endfunction

  function automatic logic control_op(input logic [31:0] inst);
    return inst[6:0] inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM};
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("[ERROR] %s exp=%h got=%h", name, exp, got);
      test_errs++;
    end
  endtask

  task automatic retire(input logic [31:0] pc, input logic [31:0] inst);
    if (pos >= nstream) begin
      $display("instruction at %h was delivered after the end of the stream", pc);
      test_errs++;
    end else begin
      compare("pc_o", exp_pc[pos], pc);
      compare("inst_o", exp_inst[pos], inst);
      pos++;
    end
  endtask

  task automatic drive_inputs();
    rvalid_i        = nxt_rvalid;
    rdata_i         = nxt_rdata;
    next_ready_i    = nxt_ready;
    resolve_valid_i = nxt_resolve;
    resolve_pc_i    = res_pc;
    resolve_npc_i   = res_npc;
  endtask

  // samples the DUT late in the cycle and works out the next inputs.
  task automatic observe();
    int v;
    int bi;
    nxt_rvalid = 1'b0;
    if (rvalid_i) begin
      bus_cnt++;
    end else if (arvalid_o) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        v = take_bits(2);
        mem_wait = v % 3 + 1;
      end
      mem_wait--;
      if (mem_wait == 0) begin
        nxt_rvalid = 1'b1;
        nxt_rdata  = read_word(araddr_o);
        mem_busy   = 1'b0;
      end
    end
    if (resolve_valid_i) begin
      if (mispredict_o) begin
        mis_cnt++;
        spq_pc.delete();
        spq_inst.delete();
      end else begin
        while (spq_pc.size() > 0) retire(spq_pc.pop_front(), spq_inst.pop_front());
      end
      bi = resolve_pc_i[3:2];
      btb_v[bi]   = 1'b1;
      btb_tag[bi] = resolve_pc_i;
      btb_tgt[bi] = resolve_npc_i;
    end
    nxt_resolve = 1'b0;
    if (res_wait > 0) begin
      res_wait--;
      nxt_resolve = (res_wait == 0);
    end
    // a delivery in the cycle that retires the last stream entry lies past the test.
    if (valid_o && next_ready_i && pos < nstream) begin
      if (spec_chk) compare("spec_o", 32'd1, spec_o);
      spec_chk = 1'b0;
      if (spec_o && !resolve_valid_i) begin
        spq_pc.push_back(pc_o);
        spq_inst.push_back(inst_o);
      end else begin
        retire(pc_o, inst_o);
      end
      if (control_op(inst_o)) begin
        bi       = pc_o[3:2];
        spec_chk = btb_v[bi] && (btb_tag[bi] == pc_o); // the model expects a prediction.
        res_wait = 1;
        res_pc   = pc_o;
        res_npc  = (pos < nstream) ? exp_pc[pos] : pc_o + 4;
      end
      if (inst_o == INST_FENCE_I && pc_o == fence_pc) begin
        for (int i = 0; i < npatch; i++) mem[(patch_addr[i] - PC_INIT) >> 2] = patch_data[i];
      end
    end
    if (resolve_valid_i) spec_chk = 1'b0;
    nxt_ready = 1'b1;
    if (backpressure != 0) begin
      v = take_bits(1);
      nxt_ready = v[0];
    end
  endtask

  task automatic reset_dut();
    rst_req = 1'b1;
    drive_inputs();
    @(posedge clk);
    #1;
    rst_req = 1'b0;
    while (rst) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_test(input int num, inout int p);
    int nmem;
    int exp_mis;
    int exp_bus;
    nmem = tdata[p];
    npatch = tdata[p+1];
    fence_pc = PC_INIT + tdata[p+2];
    nstream = tdata[p+3];
    exp_mis = tdata[p+4];
    exp_bus = tdata[p+5];
    backpressure = tdata[p+6];
    p += 7;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(PC_INIT + 4 * i);
    for (int i = 0; i < nmem; i++) mem[i] = tdata[p+i];
    p += nmem;
    for (int i = 0; i < npatch; i++) begin
      patch_addr[i] = PC_INIT + tdata[p+2*i];
      patch_data[i] = tdata[p+2*i+1];
    end
    p += 2 * npatch;
    for (int i = 0; i < nstream; i++) begin
      exp_pc[i]   = PC_INIT + tdata[p+2*i];
      exp_inst[i] = tdata[p+2*i+1];
    end
    p += 2 * nstream;
    pos = 0;
    mis_cnt = 0;
    bus_cnt = 0;
    test_errs = 0;
    mem_busy = 1'b0;
    mem_wait = 0;
    res_wait = 0;
    spec_chk = 1'b0;
    spq_pc.delete();
    spq_inst.delete();
    for (int i = 0; i < 4; i++) btb_v[i] = 1'b0;
    {nxt_rvalid, nxt_resolve, nxt_rdata, res_pc, res_npc} = '0;
    nxt_ready = 1'b1;
    reset_dut();
    while (pos < nstream) begin
      drive_inputs();
      #6;
      observe();
      @(posedge clk);
      #1;
    end
    compare("mispredict count", exp_mis, mis_cnt);
    compare("bus read count", exp_bus, bus_cnt);
    if (test_errs != 0) failed++;
    errors += test_errs;
    $display("test %0d %s: %0d retired, %0d mispredicts, %0d bus reads",
             num, (test_errs == 0) ? "passed" : "failed", pos, mis_cnt, bus_cnt);
  endtask

  initial begin
    int p;
    int ntests;
    int total;
    int chk_fails;
    rst_req = 1'b0;
    {rvalid_i, next_ready_i, resolve_valid_i} = '0;
    {rdata_i, resolve_pc_i, resolve_npc_i} = '0;
    {nxt_rvalid, nxt_ready, nxt_resolve, nxt_rdata, res_pc, res_npc} = '0;
    lfsr = LFSR_SEED;
    {errors, failed, cycles, limit, ntests, backpressure} = '0;
    $readmemh(TEST_FILE, tdata);
    if ($isunknown(tdata[0])) begin
      $display("test file %s could not be read", TEST_FILE);
      errors++;
    end else begin
      ntests = tdata[0];
      p = 1;
      total = 0;
      for (int t = 0; t < ntests; t++) begin
        total += tdata[p+3];
        p += 7 + tdata[p] + 2 * tdata[p+1] + 2 * tdata[p+3];
      end
      limit = 200 * total;
      p = 1;
      for (int t = 0; t < ntests; t++) run_test(t + 1, p);
    end
    chk_fails = i_ifu_top.i_ifu_chk.fail_cnt;
    $display("tests %0d, failed %0d, mismatches %0d, assertion failures %0d",
             ntests, failed, errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- ifu.f
hw/ifu_pkg.sv
hw/icache_if.sv
hw/btb.sv
hw/icache.sv
hw/ifu_ctrl.sv
hw/ifu_top.sv
verification/tb_clk_gen.sv
verification/ifu_chk.sv
verification/tb_ifu.sv

//--- verification/ifu_tests.txt
// per test: header "nmem npatch fence_off nstream mispredicts bus_reads backpressure", then
// memory words from the reset pc, patch pairs "offset word", stream pairs "offset word".
06
04 00 00 07 00 04 00  00100093 00200113 00300193 ff5ff06f
00 00100093 04 00200113 08 00300193 0c ff5ff06f 00 00100093 04 00200113 08 00300193
05 00 00 04 00 06 00  00100093 0080006f 00300193 00400213 00500293
00 00100093 04 0080006f 0c 00400213 10 00500293
04 00 00 0a 00 04 00  00100093 00200113 fe209ce3 00400213
00 00100093 04 00200113 08 fe209ce3 00 00100093 04 00200113 08 fe209ce3
00 00100093 04 00200113 08 fe209ce3 00 00100093
05 00 00 08 01 06 00  00100093 00200113 fe209ce3 00400213 00500293
00 00100093 04 00200113 08 fe209ce3 00 00100093 04 00200113 08 fe209ce3
0c 00400213 10 00500293
04 01 08 04 00 06 00  00100093 00200113 0000100f 00400213  0c 00900493
00 00100093 04 00200113 08 0000100f 0c 00900493
05 00 00 08 01 06 01  00100093 00200113 fe209ce3 00400213 00500293
00 00100093 04 00200113 08 fe209ce3 00 00100093 04 00200113 08 fe209ce3
0c 00400213 10 00500293
